// ==== common/l2_cache_pkg.sv ====
package l2_cache_pkg;

	// Address and bus widths of the 16-bit byte-addressed memory system.
	localparam int ADDR_W = 16;
	localparam int HALF_W = 128; // One L1 transfer.
	localparam int LINE_W = 2 * HALF_W; // One memory transfer.

	// Cache geometry.
	localparam int SETS = 8;
	localparam int INDEX_W = $clog2(SETS);
	localparam int OFFSET_W = $clog2(LINE_W / 8);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [HALF_W-1:0] half_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;

	// Controller states.
	// st_check looks up the request and answers hits in the same cycle.
	// st_writeback sends the dirty victim line to memory.
	// st_allocate fetches the missing line and writes it into the LRU way.
	typedef enum logic [1:0]
	{
		st_check,
		st_writeback,
		st_allocate
	} l2_state_t;

endpackage

// ==== logic/l2_array.sv ====
`timescale 1ns/1ps

module l2_array #(
	parameter int width = 1,
	parameter int index_width = 3
) (
	input logic clk,
	input logic rst_n,
	input logic write,
	input logic [index_width-1:0] index,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	localparam int DEPTH = 2 ** index_width;

	logic [width-1:0] entries [DEPTH];

	// Every entry comes out of reset cleared so valid, dirty and LRU start at zero.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				entries[i] <= '0;
		end
		else if (write)
			entries[index] <= datain;
	end

	assign dataout = entries[index]; // Read is combinational.

endmodule

// ==== l2_cache/l2_cache_datapath.sv ====
`timescale 1ns/1ps

module l2_cache_datapath import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input addr_t mem_address,
	input half_t mem_wdata,
	input logic mem_read,
	input logic mem_write,
	input line_t pmem_rdata,
	input logic data_write,
	input logic allocate,
	input logic dirty_in,
	input logic valid_in,
	input logic addr_sel,
	output half_t mem_rdata,
	output addr_t pmem_address,
	output line_t pmem_wdata,
	output logic cache_hit,
	output logic victim_dirty
);

	tag_t tag;
	index_t index;
	logic half_sel;

	line_t data_out [2];
	tag_t tag_out [2];
	logic [1:0] valid_out;
	logic [1:0] dirty_out;
	logic [1:0] hit;
	logic [1:0] way_write;

	logic hit_way;
	logic lru; // Names the least recently used way of the set.
	logic lru_write;
	logic target_way;
	line_t hit_line;
	line_t merged_line;
	line_t line_in;

	assign tag = mem_address[ADDR_W-1 -: TAG_W];
	assign index = mem_address[OFFSET_W +: INDEX_W];
	assign half_sel = mem_address[OFFSET_W-1]; // Lower bits select bytes inside a half-line.

	// Per-way storage. All arrays of a way share the same write strobe.
	for (genvar w = 0; w < 2; w++)
	begin : g_way
		l2_array #(
			.width(LINE_W),
			.index_width(INDEX_W)
		) u_data (
			.clk,
			.rst_n,
			.write(way_write[w]),
			.index,
			.datain(line_in),
			.dataout(data_out[w])
		);

		l2_array #(
			.width(TAG_W),
			.index_width(INDEX_W)
		) u_tag (
			.clk,
			.rst_n,
			.write(way_write[w]),
			.index,
			.datain(tag),
			.dataout(tag_out[w])
		);

		l2_array #(
			.width(1),
			.index_width(INDEX_W)
		) u_valid (
			.clk,
			.rst_n,
			.write(way_write[w]),
			.index,
			.datain(valid_in),
			.dataout(valid_out[w])
		);

		l2_array #(
			.width(1),
			.index_width(INDEX_W)
		) u_dirty (
			.clk,
			.rst_n,
			.write(way_write[w]),
			.index,
			.datain(dirty_in),
			.dataout(dirty_out[w])
		);

		assign hit[w] = valid_out[w] & (tag_out[w] == tag);
	end

	assign cache_hit = |hit;
	assign hit_way = hit[1];

	// A fill goes to the LRU way, anything else to the way that hit.
	assign target_way = allocate ? lru : hit_way;
	assign way_write[0] = data_write & ~target_way;
	assign way_write[1] = data_write & target_way;

	assign hit_line = hit_way ? data_out[1] : data_out[0];

	// An L1 write replaces the addressed half and keeps the other.
	assign merged_line = half_sel ? {mem_wdata, hit_line[HALF_W-1:0]}
	                              : {hit_line[LINE_W-1:HALF_W], mem_wdata};
	assign line_in = allocate ? pmem_rdata : merged_line;

	assign mem_rdata = half_sel ? hit_line[LINE_W-1:HALF_W] : hit_line[HALF_W-1:0];

	// A hit always completes its request in the same cycle, so each hit cycle
	// is the first and only one of that request.
	assign lru_write = cache_hit & (mem_read | mem_write);

	l2_array #(
		.width(1),
		.index_width(INDEX_W)
	) u_lru (
		.clk,
		.rst_n,
		.write(lru_write),
		.index,
		.datain(~hit_way), // The way not touched becomes LRU.
		.dataout(lru)
	);

	assign victim_dirty = lru ? dirty_out[1] : dirty_out[0];
	assign pmem_wdata = lru ? data_out[1] : data_out[0];

	// Writeback goes to the victim's own line, a fill to the requested one.
	assign pmem_address = addr_sel ? {tag_out[lru], index, OFFSET_W'(0)}
	                               : {tag, index, OFFSET_W'(0)};

	a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read || mem_write) |-> !(hit[0] && hit[1]))
		else $error("Both ways of set %0d hold tag %h", index, tag);

endmodule

// ==== l2_cache/l2_cache_control.sv ====
`timescale 1ns/1ps

module l2_cache_control import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input logic cache_hit,
	input logic victim_dirty,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic data_write,
	output logic allocate,
	output logic dirty_in,
	output logic valid_in,
	output logic addr_sel
);

	l2_state_t state;
	l2_state_t next_state;
	logic request;

	assign request = mem_read | mem_write;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= st_check;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		data_write = 1'b0;
		allocate = 1'b0;
		dirty_in = 1'b0;
		valid_in = 1'b0;
		addr_sel = 1'b0;

		case (state)
			st_check:
			begin
				if (request && cache_hit)
				begin
					mem_resp = 1'b1;
					if (mem_write)
					begin
						data_write = 1'b1; // Half-line merge lands at this edge.
						dirty_in = 1'b1;
						valid_in = 1'b1;
					end
				end
				else if (request)
				begin
					// A clean victim can simply be overwritten.
					if (victim_dirty)
						next_state = st_writeback;
					else
						next_state = st_allocate;
				end
			end

			st_writeback:
			begin
				pmem_write = 1'b1;
				addr_sel = 1'b1;
				if (pmem_resp)
					next_state = st_allocate;
			end

			st_allocate:
			begin
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					data_write = 1'b1;
					allocate = 1'b1;
					valid_in = 1'b1;
					next_state = st_check; // The request hits on the next cycle.
				end
			end

			default:
			begin
				next_state = st_check;
			end
		endcase
	end

	a_pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("Memory read and write requested together");

	a_resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |-> request)
		else $error("mem_resp raised with no L1 request");

	a_pmem_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_resp |-> (pmem_read || pmem_write))
		else $error("pmem_resp arrived with no memory transaction open");

	// The filled line must be found again once the request is looked up.
	a_fill_then_hit: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_allocate && pmem_resp) |=> cache_hit)
		else $error("Request missed right after its line was filled");

endmodule

// ==== l2_cache/l2_cache.sv ====
`timescale 1ns/1ps

module l2_cache import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input addr_t mem_address,
	input half_t mem_wdata,
	output half_t mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output addr_t pmem_address,
	output line_t pmem_wdata,
	input line_t pmem_rdata,
	input logic pmem_resp
);

	logic data_write;
	logic allocate;
	logic dirty_in;
	logic valid_in;
	logic addr_sel;
	logic cache_hit;
	logic victim_dirty;

	l2_cache_control u_control (
		.clk,
		.rst_n,
		.mem_read,
		.mem_write,
		.pmem_resp,
		.cache_hit,
		.victim_dirty,
		.mem_resp,
		.pmem_read,
		.pmem_write,
		.data_write,
		.allocate,
		.dirty_in,
		.valid_in,
		.addr_sel
	);

	l2_cache_datapath u_datapath (
		.clk,
		.rst_n,
		.mem_address,
		.mem_wdata,
		.mem_read,
		.mem_write,
		.pmem_rdata,
		.data_write,
		.allocate,
		.dirty_in,
		.valid_in,
		.addr_sel,
		.mem_rdata,
		.pmem_address,
		.pmem_wdata,
		.cache_hit,
		.victim_dirty
	);

endmodule

// ==== tb/pmem_model.sv ====
`timescale 1ns/1ps

module pmem_model import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input addr_t pmem_address,
	input line_t pmem_wdata,
	output line_t pmem_rdata,
	output logic pmem_resp,
	output int read_count,
	output int write_count
);

	localparam int LINES = 2048; // 64 KiB of 32-byte lines.

	line_t mem [LINES];
	logic [31:0] delay_rng;
	logic [2:0] wait_cycles;
	logic busy;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Every line runs its own stream, seeded from its line address.
	function automatic line_t fill_line(input logic [10:0] line_index);
		line_t line;
		logic [31:0] x;
		x = 32'd86107 ^ {21'd0, line_index};
		for (int w = 0; w < 8; w++)
		begin
			x = xorshift(x);
			line[w*32 +: 32] = x;
		end
		return line;
	endfunction

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < LINES; i++)
				mem[i] <= fill_line(11'(i));
			delay_rng <= 32'd86107;
			wait_cycles <= 3'd0;
			busy <= 1'b0;
			pmem_resp <= 1'b0;
			pmem_rdata <= '0;
			read_count <= 0;
			write_count <= 0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			if (pmem_resp)
				busy <= 1'b0; // The cache closes the transaction at this edge.
			else if (!busy && (pmem_read || pmem_write))
			begin
				busy <= 1'b1;
				wait_cycles <= {1'b0, delay_rng[1:0]} + 3'd1;
				delay_rng <= xorshift(delay_rng);
			end
			else if (busy)
			begin
				wait_cycles <= wait_cycles - 3'd1;
				if (wait_cycles == 3'd1)
				begin
					pmem_resp <= 1'b1;
					if (pmem_write)
					begin
						mem[pmem_address[15:5]] <= pmem_wdata;
						write_count <= write_count + 1;
					end
					else
					begin
						pmem_rdata <= mem[pmem_address[15:5]];
						read_count <= read_count + 1;
					end
				end
			end
		end
	end

endmodule

// ==== tb/tb_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l2_cache import l2_cache_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int DIRECTED_ACCESSES = 16;
	localparam int RANDOM_ACCESSES = 300;
	localparam int LINES = 2048;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	logic pmem_resp;
	addr_t mem_address;
	addr_t pmem_address;
	half_t mem_wdata;
	half_t mem_rdata;
	line_t pmem_wdata;
	line_t pmem_rdata;
	int read_count;
	int write_count;

	line_t shadow [LINES]; // What the L1 should read at every address.
	tag_t model_tag [SETS][2];
	logic model_valid [SETS][2];
	logic model_dirty [SETS][2];
	logic model_lru [SETS]; // Way that gets replaced next.
	int exp_reads;
	int exp_writes;
	logic [31:0] rng;

	l2_cache u_l2_cache (.*);
	pmem_model u_pmem (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic addr_t line_addr(input tag_t tag, input index_t set, input logic half);
		return {tag, set, half, 4'h0};
	endfunction

	task automatic check(input string name, input line_t actual, input line_t expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Finished with errors");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// Updates the reference tags, LRU bits and shadow for one request.
	task automatic predict(input logic wr, input addr_t addr, input half_t data);
		tag_t tag;
		index_t set;
		logic way;
		logic hit;
		tag = addr[15:8];
		set = addr[7:5];
		hit = 1'b0;
		way = model_lru[set];
		for (int w = 0; w < 2; w++)
		begin
			if (model_valid[set][w] && model_tag[set][w] == tag)
			begin
				hit = 1'b1;
				way = w[0];
			end
		end
		if (!hit)
		begin
			if (model_dirty[set][way])
				exp_writes++; // The victim goes back to memory first.
			exp_reads++;
			model_tag[set][way] = tag;
			model_valid[set][way] = 1'b1;
			model_dirty[set][way] = 1'b0;
		end
		model_lru[set] = ~way;
		if (wr)
		begin
			model_dirty[set][way] = 1'b1;
			shadow[addr[15:5]][{addr[4], 7'd0} +: HALF_W] = data;
		end
	endtask

	task automatic access(input logic wr, input addr_t addr, input half_t data);
		half_t expected;
		expected = shadow[addr[15:5]][{addr[4], 7'd0} +: HALF_W];
		predict(wr, addr, data);
		@(posedge clk);
		mem_read <= !wr;
		mem_write <= wr;
		mem_address <= addr;
		mem_wdata <= data;
		@(negedge clk);
		while (!mem_resp)
			@(negedge clk);
		if (!wr)
			check("mem_rdata", line_t'(mem_rdata), line_t'(expected));
		check("read_count", line_t'(read_count), line_t'(exp_reads));
		check("write_count", line_t'(write_count), line_t'(exp_writes));
		@(posedge clk);
		mem_read <= 1'b0;
		mem_write <= 1'b0;
	endtask

	// Lines still dirty in the cache are newer than memory and are skipped.
	task automatic compare_memory();
		logic resident_dirty;
		for (int i = 0; i < LINES; i++)
		begin
			resident_dirty = 1'b0;
			for (int w = 0; w < 2; w++)
				if (model_valid[i % SETS][w] && model_dirty[i % SETS][w]
					&& model_tag[i % SETS][w] == tag_t'(i / SETS))
					resident_dirty = 1'b1;
			if (!resident_dirty)
				check($sformatf("pmem line %0h", i), u_pmem.mem[i], shadow[i]);
		end
	endtask

	task automatic first_read_miss();
		check("mem_resp", line_t'(mem_resp), '0);
		check("pmem_read", line_t'(pmem_read), '0);
		check("pmem_write", line_t'(pmem_write), '0);
		access(1'b0, line_addr(8'h12, 3'd1, 1'b0), '0);
		check("read_count", line_t'(read_count), line_t'(1));
	endtask

	task automatic same_line_hits();
		access(1'b0, line_addr(8'h12, 3'd1, 1'b0), '0);
		access(1'b0, line_addr(8'h12, 3'd1, 1'b1), '0);
		check("read_count", line_t'(read_count), line_t'(1));
	endtask

	task automatic write_then_read();
		access(1'b1, line_addr(8'h12, 3'd1, 1'b1), {4{next_random()}});
		access(1'b0, line_addr(8'h12, 3'd1, 1'b1), '0);
		access(1'b0, line_addr(8'h12, 3'd1, 1'b0), '0);
		check("write_count", line_t'(write_count), '0);
	endtask

	task automatic lru_order();
		int reads;
		access(1'b0, line_addr(8'h20, 3'd3, 1'b0), '0);
		access(1'b0, line_addr(8'h21, 3'd3, 1'b0), '0);
		access(1'b0, line_addr(8'h20, 3'd3, 1'b0), '0);
		access(1'b0, line_addr(8'h22, 3'd3, 1'b0), '0); // Evicts the second line.
		reads = read_count;
		access(1'b0, line_addr(8'h20, 3'd3, 1'b1), '0);
		check("read_count", line_t'(read_count), line_t'(reads));
		access(1'b0, line_addr(8'h21, 3'd3, 1'b1), '0);
		check("read_count", line_t'(read_count), line_t'(reads + 1));
	endtask

	task automatic dirty_eviction();
		addr_t dirty_addr;
		int writes;
		dirty_addr = line_addr(8'h30, 3'd5, 1'b0);
		access(1'b1, dirty_addr, {next_random(), next_random(), next_random(), next_random()});
		access(1'b0, line_addr(8'h31, 3'd5, 1'b0), '0);
		writes = write_count;
		access(1'b0, line_addr(8'h32, 3'd5, 1'b0), '0);
		check("write_count", line_t'(write_count), line_t'(writes + 1));
		check("pmem line", u_pmem.mem[dirty_addr[15:5]], shadow[dirty_addr[15:5]]);
		access(1'b0, line_addr(8'h33, 3'd5, 1'b0), '0); // Clean victim.
		check("write_count", line_t'(write_count), line_t'(writes + 1));
		compare_memory();
	endtask

	task automatic random_mix();
		logic [31:0] r;
		half_t data;
		for (int n = 0; n < RANDOM_ACCESSES; n++)
		begin
			r = next_random();
			data = {next_random(), next_random(), next_random(), next_random()};
			access(r[0], line_addr({6'h10, r[2:1]}, r[5:3], r[6]), data);
		end
		check("read_count", line_t'(read_count), line_t'(exp_reads));
		check("write_count", line_t'(write_count), line_t'(exp_writes));
		compare_memory();
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		rng = 32'd86107;
		exp_reads = 0;
		exp_writes = 0;
		for (int s = 0; s < SETS; s++)
		begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				model_tag[s][w] = '0;
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
			end
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < LINES; i++)
			shadow[i] = u_pmem.mem[i]; // Memory contents are known once reset is over.
		first_read_miss();
		same_line_hits();
		write_then_read();
		lru_order();
		dirty_eviction();
		random_mix();
		$display("Finished with no errors");
		$finish;
	end

	initial
	begin
		#((DIRECTED_ACCESSES + RANDOM_ACCESSES) * 200 * CLK_PERIOD);
		$display("Timeout: the cache stopped answering requests");
		$display("Finished with errors");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== tb.f ====
common/l2_cache_pkg.sv
logic/l2_array.sv
l2_cache/l2_cache_datapath.sv
l2_cache/l2_cache_control.sv
l2_cache/l2_cache.sv
tb/pmem_model.sv
tb/tb_l2_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_l2_cache
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The simulator exits with a failing status on any $fatal.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
